// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/fetch_asserts.sv ====
`default_nettype none

module fetch_asserts import fetch_pkg::*; (
  input wire          clk,
  input wire          rst_n,
  input wire inst_t   inst,
  input wire          inst_valid,
  input wire addr_t   pc,
  input wire          redirect,
  input wire addr_t   redirect_pc,
  input wire          bus_req,
  input wire addr_t   bus_addr,
  input wire src_id_t bus_id,
  input wire          bus_rvalid,
  input wire addr_t   dmem_addr,
  input wire          dmem_rvalid,
  input wire word_t   dmem_rdata,
  input wire refill_state_t cache_state
);

  int unsigned failures = 0; // failed assertions so far

  addr_t load_base;
  word_t load_beat;
  addr_t target_q;  // target of the last redirect
  logic  pending_q; // redirect taken, nothing delivered since

  // beat for the held load address, upper half is base + 4
  assign load_base = {dmem_addr[31:3], 3'b000};
  assign load_beat = {(load_base + 32'd4) ^ 32'h5A5A_0000, load_base ^ 32'h5A5A_0000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      target_q  <= '0;
    end else if (redirect) begin
      pending_q <= 1'b1;
      target_q  <= redirect_pc;
    end else if (inst_valid) begin
      pending_q <= 1'b0; // first delivery after the jump seen
    end
  end

  inst_content: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid |-> inst == (pc ^ 32'h5A5A_0000))
    else begin
      failures++;
      $error("MISMATCH t=%0t inst got %h expected %h", $time, $sampled(inst),
             $sampled(pc) ^ 32'h5A5A_0000);
    end

  redirect_target: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid && pending_q |-> pc == target_q)
    else begin
      failures++;
      $error("MISMATCH t=%0t pc got %h expected %h", $time, $sampled(pc),
             $sampled(target_q));
    end

  bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req && !bus_rvalid |=> $stable(bus_addr) && $stable(bus_id))
    else begin
      failures++;
      $error("bus_addr or bus_id changed before the response");
    end

  load_data: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_rvalid |-> dmem_rdata == load_beat)
    else begin
      failures++;
      $error("MISMATCH t=%0t dmem_rdata got %h expected %h", $time,
             $sampled(dmem_rdata), $sampled(load_beat));
    end

  // a refill on the bus always belongs to the miss the cache waits on
  refill_owner: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req && bus_id == SRC_IFETCH |-> cache_state == ST_REFILL)
    else begin
      failures++;
      $error("instruction refill on the bus while the cache is not refilling");
    end

endmodule

bind fetch_top fetch_asserts u_fetch_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .inst        (inst),
  .inst_valid  (inst_valid),
  .pc          (pc),
  .redirect    (redirect),
  .redirect_pc (redirect_pc),
  .bus_req     (bus_req),
  .bus_addr    (bus_addr),
  .bus_id      (bus_id),
  .bus_rvalid  (bus_rvalid),
  .dmem_addr   (dmem_addr),
  .dmem_rvalid (dmem_rvalid),
  .dmem_rdata  (dmem_rdata),
  .cache_state (u_icache.state)
);

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  localparam int SEED       = 47;
  localparam int MAX_CYCLES = 3000; // about 4x a full run of the five tests

  logic    clk;
  logic    rst_n;
  logic    fetch_stall;
  logic    redirect;
  addr_t   redirect_pc;
  inst_t   inst;
  logic    inst_valid;
  addr_t   pc;
  logic    dmem_req;
  addr_t   dmem_addr;
  logic    dmem_rvalid;
  word_t   dmem_rdata;
  logic    bus_req;
  addr_t   bus_addr;
  src_id_t bus_id;
  logic    bus_rvalid;
  word_t   bus_rdata;
  src_id_t bus_rid;

  int unsigned errors      = 0;
  int unsigned test_errors = 0; // errors before the current test
  int unsigned delivered   = 0;
  int unsigned loads_done  = 0;
  int unsigned fetch_reqs  = 0;
  int unsigned cycles      = 0;

  // monitor state
  addr_t next_pc;
  addr_t pc_q;
  logic  stall_q;
  logic  redirect_q;
  logic  bus_req_q;
  logic  bus_open;

  fetch_top dut0 (.*);

  always #10 clk = ~clk;

  // memory content: instruction at a is a xor 5A5A_0000
  function automatic inst_t inst_at(input addr_t a);
    return a ^ 32'h5A5A_0000;
  endfunction

  function automatic word_t beat_at(input addr_t a);
    addr_t base;
    base = {a[31:3], 3'b000};
    return {inst_at(base + 32'd4), inst_at(base)};
  endfunction

  // own checks plus bound assertion failures
  function automatic int unsigned total_errors();
    return errors + dut0.u_fetch_asserts.failures;
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input string name);
    $display("%s: done at %0t, %0d errors", name, $time, total_errors() - test_errors);
    test_errors = total_errors();
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_deliveries(input int unsigned n);
    int unsigned target;
    target = delivered + n;
    while (delivered < target) @(negedge clk);
  endtask

  task automatic pulse_redirect(input addr_t target);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect    = 1'b0;
  endtask

  // dmem_req held until the response comes back
  task automatic issue_load(input addr_t addr);
    int unsigned target;
    target    = loads_done + 1;
    dmem_addr = addr;
    dmem_req  = 1'b1;
    @(negedge clk);
    while (loads_done < target) @(negedge clk);
    dmem_req  = 1'b0;
  endtask

  // bus memory, answers 1 to 4 cycles after bus_req
  initial begin : memory_model
    int unsigned delay;
    logic        busy;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    bus_rid    = '0;
    busy       = 1'b0;
    delay      = 0;
    forever begin
      @(negedge clk);
      bus_rvalid = 1'b0;
      if (rst_n && bus_req && !busy) begin
        busy  = 1'b1;
        delay = $urandom % 4;
      end
      if (busy) begin
        if (delay == 0) begin
          bus_rvalid = 1'b1;
          bus_rdata  = beat_at(bus_addr);
          bus_rid    = bus_id;
          busy       = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  // values read before the edge updates anything
  always @(posedge clk) begin
    if (!rst_n) begin
      next_pc    = RESET_PC;
      pc_q       = RESET_PC;
      stall_q    = 1'b0;
      redirect_q = 1'b0;
      bus_req_q  = 1'b0;
      bus_open   = 1'b0;
    end else begin
      if (stall_q && !redirect_q && pc != pc_q) begin
        report_mismatch("pc during stall", word_t'(pc), word_t'(pc_q));
      end
      if (inst_valid && !fetch_stall) begin
        if (pc != next_pc) report_mismatch("pc", word_t'(pc), word_t'(next_pc));
        if (inst != inst_at(pc)) report_mismatch("inst", word_t'(inst), word_t'(inst_at(pc)));
        delivered++;
        next_pc = pc + 32'd4;
      end
      if (redirect) next_pc = redirect_pc; // first delivery after must be the target
      if (dmem_rvalid) begin
        if (dmem_rdata != beat_at(dmem_addr)) begin
          report_mismatch("dmem_rdata", dmem_rdata, beat_at(dmem_addr));
        end
        loads_done++;
      end
      if (bus_req && !bus_req_q) begin
        if (bus_open) report_failure("bus_req rose while a transaction was still open");
        bus_open = 1'b1;
        if (bus_id == SRC_IFETCH) fetch_reqs++;
      end
      if (bus_rvalid) begin
        if (!bus_open) report_failure("bus response arrived with no open transaction");
        bus_open = 1'b0;
      end
      pc_q       = pc;
      stall_q    = fetch_stall;
      redirect_q = redirect;
      bus_req_q  = bus_req;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned base;
    addr_t       target;
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_stall = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    dmem_req    = 1'b0;
    dmem_addr   = '0;
    repeat (3) @(negedge clk);
    if (pc != RESET_PC) report_mismatch("pc at reset", word_t'(pc), word_t'(RESET_PC));
    rst_n = 1'b1;

    // 1: 40 instructions from reset, 20 lines, each a miss
    wait_deliveries(40);
    fetch_stall = 1'b1; // park until the trailing refill lands
    while (!inst_valid) @(negedge clk);
    // 20 lines plus the line at the stop address
    if (fetch_reqs != 21) report_failure("sequential fetch did not make one refill per line");
    end_test("sequential fetch");

    // 2: only 16 lines, so the last 128 bytes fetched are resident
    base        = fetch_reqs;
    fetch_stall = 1'b0;
    pulse_redirect(RESET_PC + 32'h28);
    wait_deliveries(32);
    if (fetch_reqs != base) report_failure("refill issued while refetching resident lines");
    end_test("hits after fill");

    // 3: redirects, the first one taken mid refill
    pulse_redirect(RESET_PC + 32'h800);
    while (!(bus_req && bus_id == SRC_IFETCH)) @(negedge clk);
    pulse_redirect(RESET_PC + 32'h404);
    wait_deliveries(2);
    for (int i = 0; i < 8; i++) begin
      wait_cycles($urandom % 6);
      target = RESET_PC + 32'h400 + ($urandom % 128) * 32'd8 + (i % 2) * 4;
      pulse_redirect(target);
      wait_deliveries(1 + $urandom % 3);
    end
    end_test("redirect");

    // 4: random stall spans
    for (int i = 0; i < 5; i++) begin
      wait_deliveries(1 + $urandom % 3);
      fetch_stall = 1'b1;
      wait_cycles(1 + $urandom % 6);
      fetch_stall = 1'b0;
    end
    wait_deliveries(2);
    end_test("stall");

    // 5: loads racing cold fetches for the bus
    for (int i = 0; i < 6; i++) begin
      pulse_redirect(RESET_PC + 32'h2000 + i * 32'h100);
      wait_cycles($urandom % 3);
      issue_load($urandom);
    end
    wait_deliveries(2);
    end_test("shared bus");

    $display("summary: %0d instructions, %0d loads, %0d errors", delivered, loads_done,
             total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] inst_t;   // one instruction
  typedef logic [63:0] word_t;   // one bus beat, also one cache line
  typedef logic [1:0]  src_id_t; // bus source id

  // source ids carried on bus_id and bus_rid
  localparam src_id_t SRC_IFETCH = 2'd1; // cache refill
  localparam src_id_t SRC_DATA   = 2'd2; // data load

  localparam addr_t RESET_PC = 32'h8000_0000;
  localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  // direct mapped, one 8 byte line per index
  localparam int LINE_COUNT = 16;
  localparam int INDEX_W    = 4;  // addr[6:3]
  localparam int TAG_W      = 25; // addr[31:7]

  // miss sequencing in the instruction cache
  typedef enum logic [1:0] {
    ST_LOOKUP, // normal lookup, a miss starts a refill
    ST_REFILL, // refill_req held until refill_done
    ST_FILL    // line written, first cycle it can hit
  } refill_state_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  // core side
  input  wire          fetch_stall,
  input  wire          redirect,
  input  wire addr_t   redirect_pc,
  output wire inst_t   inst,
  output wire          inst_valid,
  output wire addr_t   pc,
  input  wire          dmem_req,
  input  wire addr_t   dmem_addr,
  output wire          dmem_rvalid,
  output wire word_t   dmem_rdata,
  // shared read bus
  output wire          bus_req,
  output wire addr_t   bus_addr,
  output wire src_id_t bus_id,
  input  wire          bus_rvalid,
  input  wire word_t   bus_rdata,
  input  wire src_id_t bus_rid
);

  // cache refill path into the arbiter
  wire        refill_req;
  wire addr_t refill_addr;
  wire        refill_done;
  wire word_t refill_data;

  pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_stall (fetch_stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_valid  (inst_valid), // advance on delivery
    .pc          (pc)
  );

  icache u_icache (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .redirect    (redirect),
    .refill_done (refill_done),
    .refill_data (refill_data),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .refill_req  (refill_req),
    .refill_addr (refill_addr)
  );

  mem_arbiter u_mem_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .dmem_req    (dmem_req),
    .dmem_addr   (dmem_addr),
    .bus_rvalid  (bus_rvalid),
    .bus_rdata   (bus_rdata),
    .bus_rid     (bus_rid),
    .refill_done (refill_done),
    .refill_data (refill_data),
    .dmem_rvalid (dmem_rvalid),
    .dmem_rdata  (dmem_rdata),
    .bus_req     (bus_req),
    .bus_addr    (bus_addr),
    .bus_id      (bus_id)
  );

endmodule

`default_nettype wire

// ==== verilog/icache.sv ====
`default_nettype none

module icache import fetch_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire addr_t pc,
  input  wire        redirect,
  input  wire        refill_done,
  input  wire word_t refill_data,
  output inst_t      inst,
  output logic       inst_valid,
  output logic       refill_req,
  output addr_t      refill_addr
);

  // line storage
  word_t                 line_data [LINE_COUNT];
  logic [TAG_W-1:0]      line_tag  [LINE_COUNT];
  logic [LINE_COUNT-1:0] line_valid;

  refill_state_t state;
  refill_state_t state_next;
  logic          squash_q; // redirect seen last cycle

  logic [INDEX_W-1:0] lookup_idx;
  logic [TAG_W-1:0]   lookup_tag;
  logic [INDEX_W-1:0] fill_idx;
  word_t              lookup_line;
  inst_t              lookup_inst;
  logic               hit;
  logic               squash;
  logic               miss_start;
  logic               fill_we;

  // address split, bits 2:0 select the word inside the line
  assign lookup_idx  = pc[3 +: INDEX_W];
  assign lookup_tag  = pc[31 -: TAG_W];
  assign fill_idx    = refill_addr[3 +: INDEX_W];

  assign lookup_line = line_data[lookup_idx];
  assign lookup_inst = pc[2] ? lookup_line[63:32] : lookup_line[31:0];
  assign hit         = line_valid[lookup_idx] && (line_tag[lookup_idx] == lookup_tag);

  // redirect cycle and the one after show a NOP
  assign squash      = redirect | squash_q;
  assign inst_valid  = hit & ~squash;
  assign inst        = inst_valid ? lookup_inst : NOP_INST;

  // no refill for the old pc while the redirect is being taken
  assign miss_start  = (state == ST_LOOKUP) & ~hit & ~redirect;

  assign refill_req  = (state == ST_REFILL);
  assign fill_we     = refill_req & refill_done; // in-flight refill always lands

  always_comb begin
    state_next = state;
    case (state)
      ST_LOOKUP: begin
        if (miss_start) begin
          state_next = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (refill_done) begin
          state_next = ST_FILL;
        end
      end
      ST_FILL: begin
        state_next = ST_LOOKUP; // hit is served here, next miss from lookup
      end
      default: begin
        state_next = ST_LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_LOOKUP;
      squash_q   <= 1'b0;
      line_valid <= '0;
    end else begin
      state    <= state_next;
      squash_q <= redirect;
      if (fill_we) begin
        line_valid[fill_idx] <= 1'b1;
      end
    end
  end

  // data, tags and the miss address
  always_ff @(posedge clk) begin
    if (miss_start) begin
      refill_addr <= {pc[31:3], 3'b000}; // line aligned
    end
    if (fill_we) begin
      line_data[fill_idx] <= refill_data;
      line_tag[fill_idx]  <= refill_addr[31 -: TAG_W];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import fetch_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          refill_req,
  input  wire addr_t   refill_addr,
  input  wire          dmem_req,
  input  wire addr_t   dmem_addr,
  input  wire          bus_rvalid,
  input  wire word_t   bus_rdata,
  input  wire src_id_t bus_rid,
  output logic         refill_done,
  output word_t        refill_data,
  output logic         dmem_rvalid,
  output word_t        dmem_rdata,
  output logic         bus_req,
  output addr_t        bus_addr,
  output src_id_t      bus_id
);

  logic resp_q; // response seen last cycle
  logic idle;
  logic grant_data;
  logic grant_fetch;

  // one transaction at a time, plus one quiet cycle after each response
  // so a requester can drop its level before the next grant
  assign idle        = ~bus_req & ~resp_q;
  assign grant_data  = idle & dmem_req;               // data first
  assign grant_fetch = idle & ~dmem_req & refill_req;

  // response routing by source id
  assign refill_done = bus_rvalid && (bus_rid == SRC_IFETCH);
  assign dmem_rvalid = bus_rvalid && (bus_rid == SRC_DATA);
  assign refill_data = bus_rdata;
  assign dmem_rdata  = bus_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_req <= 1'b0;
      resp_q  <= 1'b0;
    end else begin
      resp_q <= bus_req & bus_rvalid;
      if (grant_data | grant_fetch) begin
        bus_req <= 1'b1;
      end else if (bus_rvalid) begin
        bus_req <= 1'b0; // low in the cycle after the response
      end
    end
  end

  // address and id held stable for the whole transaction
  always_ff @(posedge clk) begin
    if (grant_data) begin
      bus_addr <= {dmem_addr[31:3], 3'b000}; // beat containing the load
      bus_id   <= SRC_DATA;
    end else if (grant_fetch) begin
      bus_addr <= refill_addr;
      bus_id   <= SRC_IFETCH;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`default_nettype none

module pc_gen import fetch_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        fetch_stall,
  input  wire        redirect,
  input  wire addr_t redirect_pc,
  input  wire        inst_valid,
  output addr_t      pc
);

  addr_t pc_next;
  logic  advance;

  // instruction on inst taken by the core this cycle
  assign advance = inst_valid & ~fetch_stall;

  always_comb begin
    pc_next = pc; // hold by default, covers stall and miss
    if (redirect) begin
      pc_next = redirect_pc; // jump wins over the step
    end else if (advance) begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/fetch_top.sv
verif/fetch_asserts.sv
verif/fetch_tb.sv
